// File: files.f
src/stream_pkg.sv
src/udp_pkg.sv
src/stream_if.sv
src/udp_rx_ctrl.sv
src/stream_out_buf.sv
src/udp_rx_top.sv
test/tb_clock.sv
test/tb_udp_rx.sv

// File: run.sh
#!/bin/sh
# build and run the UDP receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_udp_rx \
    -o sim_udp_rx

./obj_dir/sim_udp_rx | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi

// File: src/stream_if.sv
//////////////////////////////
// payload stream, valid marks a word that moves
//////////////////////////////
`timescale 1ns/1ps

interface stream_if #(
    parameter int DATA_BYTES = 8
);

    logic [DATA_BYTES*8-1:0] data;
    logic [DATA_BYTES-1:0] keep;
    logic valid;
    logic ready;
    logic last;
    logic user;

    modport src (
        output data, keep, valid, last, user,
        input ready
    );

    modport snk (
        input data, keep, valid, last, user,
        output ready
    );

endinterface

// File: src/stream_out_buf.sv
//////////////////////////////
// in_stream.valid means the word is taken this cycle
// ready toward the source is combinational
//////////////////////////////
`timescale 1ns/1ps

module stream_out_buf #(
    parameter int DATA_BYTES = stream_pkg::DATA_BYTES
) (
    input  logic                    clk,
    input  logic                    rst,
    stream_if.snk                   in_stream,
    output logic [DATA_BYTES*8-1:0] m_data,
    output logic [DATA_BYTES-1:0]   m_keep,
    output logic                    m_valid,
    output logic                    m_last,
    output logic                    m_user,
    input  logic                    m_ready
);

    logic [DATA_BYTES*8-1:0] tmp_data;
    logic [DATA_BYTES-1:0] tmp_keep;
    logic tmp_last, tmp_user;
    logic tmp_valid;
    logic out_valid_next, tmp_valid_next;
    logic in_to_out, in_to_tmp, tmp_to_out;

    // ready next cycle unless the temp register could be filled
    assign in_stream.ready = m_ready || (!tmp_valid && (!m_valid || !in_stream.valid));

    always_comb begin
        out_valid_next = m_valid;
        tmp_valid_next = tmp_valid;
        in_to_out = 1'b0;
        in_to_tmp = 1'b0;
        tmp_to_out = 1'b0;
        if (in_stream.valid) begin
            if (m_ready || !m_valid) begin
                out_valid_next = 1'b1;
                in_to_out = 1'b1;
            end else begin
                tmp_valid_next = 1'b1;
                in_to_tmp = 1'b1;
            end
        end else if (m_ready) begin
            // drain the temp register, may be empty
            out_valid_next = tmp_valid;
            tmp_valid_next = 1'b0;
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
            tmp_valid <= 1'b0;
        end else begin
            m_valid <= out_valid_next;
            tmp_valid <= tmp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            m_data <= in_stream.data;
            m_keep <= in_stream.keep;
            m_last <= in_stream.last;
            m_user <= in_stream.user;
        end else if (tmp_to_out) begin
            m_data <= tmp_data;
            m_keep <= tmp_keep;
            m_last <= tmp_last;
            m_user <= tmp_user;
        end
        if (in_to_tmp) begin
            tmp_data <= in_stream.data;
            tmp_keep <= in_stream.keep;
            tmp_last <= in_stream.last;
            tmp_user <= in_stream.user;
        end
    end

    // source must have seen the early ready drop
    a_no_overrun: assert property (
        @(posedge clk) disable iff (rst)
        in_stream.valid |-> !(m_valid && tmp_valid)
    );

endmodule

// File: src/stream_pkg.sv
//////////////////////////////
// byte-lane stream types for the 64-bit datapath
// keep masks must be contiguous from lane 0
//////////////////////////////
package stream_pkg;

    parameter int DATA_BYTES = 8;

    typedef logic [DATA_BYTES*8-1:0] data_t;
    typedef logic [DATA_BYTES-1:0] keep_t;
    typedef logic [$clog2(DATA_BYTES+1)-1:0] count_t;

    // number of valid lanes in a contiguous mask
    function automatic count_t keep_to_count(keep_t keep);
        count_t n;
        n = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (keep[i]) begin
                n = count_t'(i + 1);
            end
        end
        return n;
    endfunction

    // lanes below count are set
    function automatic keep_t count_to_keep(count_t count);
        keep_t k;
        k = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            k[i] = (i < count);
        end
        return k;
    endfunction

endpackage

// File: src/udp_pkg.sv
//////////////////////////////
// UDP header as it sits in the first payload word
// fields are in network byte order, lane 0 first
//////////////////////////////
package udp_pkg;

    parameter int UDP_HDR_BYTES = 8;

    typedef logic [15:0] port_t;
    typedef logic [31:0] ip_addr_t;

    // last member sits in lanes 0 and 1
    typedef struct packed {
        port_t checksum;
        port_t length;
        port_t dest_port;
        port_t source_port;
    } udp_hdr_t;

    // header view for capture, lane view for byte order
    typedef union packed {
        udp_hdr_t hdr;
        logic [UDP_HDR_BYTES-1:0][7:0] lanes;
    } udp_word_u;

endpackage

// File: src/udp_rx_ctrl.sv
//////////////////////////////
// UDP length below 9 is not handled
// header must fit the first 64-bit word
//////////////////////////////
`timescale 1ns/1ps

module udp_rx_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               s_hdr_valid,
    output logic               s_hdr_ready,
    input  udp_pkg::ip_addr_t  s_ip_source_ip,
    input  udp_pkg::ip_addr_t  s_ip_dest_ip,
    input  stream_pkg::data_t  s_payload_data,
    input  stream_pkg::keep_t  s_payload_keep,
    input  logic               s_payload_valid,
    output logic               s_payload_ready,
    input  logic               s_payload_last,
    input  logic               s_payload_user,
    output logic               m_hdr_valid,
    input  logic               m_hdr_ready,
    output udp_pkg::ip_addr_t  m_ip_source_ip,
    output udp_pkg::ip_addr_t  m_ip_dest_ip,
    output udp_pkg::port_t     m_udp_source_port,
    output udp_pkg::port_t     m_udp_dest_port,
    output udp_pkg::port_t     m_udp_length,
    output udp_pkg::port_t     m_udp_checksum,
    output logic               error_header_early_termination,
    output logic               error_payload_early_termination,
    stream_if.src              out_stream
);
    import stream_pkg::*;
    import udp_pkg::*;

    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_HEADER    = 2'd1;
    localparam logic [1:0] ST_PAYLOAD   = 2'd2;
    localparam logic [1:0] ST_HOLD_LAST = 2'd3;

    logic [1:0] state, state_next;
    logic hdr_ready_reg, hdr_ready_next;
    logic payload_ready_reg, payload_ready_next;
    logic hdr_valid_reg, hdr_valid_next;
    logic hdr_err_reg, hdr_err_next;
    logic pay_err_reg, pay_err_next;
    logic [15:0] remain_reg, remain_next;
    logic store_ip, store_udp, store_last;
    logic word_in;
    logic [15:0] udp_len;

    udp_word_u in_word;
    udp_word_u udp_hdr_reg;
    data_t last_data_reg;
    keep_t last_keep_reg;

    data_t out_data;
    keep_t out_keep;
    logic out_valid, out_last, out_user;

    assign in_word = s_payload_data;
    assign word_in = s_payload_valid && payload_ready_reg;
    // length field arrives high byte first
    assign udp_len = {in_word.hdr.length[7:0], in_word.hdr.length[15:8]};

    always_comb begin
        state_next = state;
        hdr_ready_next = 1'b0;
        payload_ready_next = 1'b0;
        hdr_valid_next = hdr_valid_reg && !m_hdr_ready;
        hdr_err_next = 1'b0;
        pay_err_next = 1'b0;
        remain_next = remain_reg;
        store_ip = 1'b0;
        store_udp = 1'b0;
        store_last = 1'b0;
        out_data = s_payload_data;
        out_keep = s_payload_keep;
        out_valid = 1'b0;
        out_last = s_payload_last;
        out_user = s_payload_user;

        case (state)
            ST_IDLE: begin
                // no new header while the previous one is still pending
                hdr_ready_next = !hdr_valid_next;
                if (s_hdr_valid && hdr_ready_reg) begin
                    hdr_ready_next = 1'b0;
                    payload_ready_next = 1'b1;
                    store_ip = 1'b1;
                    state_next = ST_HEADER;
                end
            end
            ST_HEADER: begin
                payload_ready_next = 1'b1;
                if (word_in) begin
                    if (s_payload_last) begin
                        hdr_err_next = 1'b1;
                        hdr_ready_next = !hdr_valid_next;
                        payload_ready_next = 1'b0;
                        state_next = ST_IDLE;
                    end else begin
                        store_udp = 1'b1;
                        hdr_valid_next = 1'b1;
                        remain_next = udp_len - 16'(UDP_HDR_BYTES);
                        payload_ready_next = out_stream.ready;
                        state_next = ST_PAYLOAD;
                    end
                end
            end
            ST_PAYLOAD: begin
                payload_ready_next = out_stream.ready;
                if (word_in) begin
                    out_valid = 1'b1;
                    if (remain_reg <= 16'(DATA_BYTES)) begin
                        // final word of the UDP payload
                        out_keep = s_payload_keep & count_to_keep(count_t'(remain_reg));
                        if (s_payload_last) begin
                            if (16'(keep_to_count(s_payload_keep)) < remain_reg) begin
                                pay_err_next = 1'b1;
                                out_user = 1'b1;
                            end
                            payload_ready_next = 1'b0;
                            hdr_ready_next = !hdr_valid_next;
                            state_next = ST_IDLE;
                        end else begin
                            // padding follows, keep the word until last
                            out_valid = 1'b0;
                            store_last = 1'b1;
                            state_next = ST_HOLD_LAST;
                        end
                    end else begin
                        remain_next = remain_reg - 16'(DATA_BYTES);
                        if (s_payload_last) begin
                            pay_err_next = 1'b1;
                            out_user = 1'b1;
                            payload_ready_next = 1'b0;
                            hdr_ready_next = !hdr_valid_next;
                            state_next = ST_IDLE;
                        end
                    end
                end
            end
            ST_HOLD_LAST: begin
                payload_ready_next = out_stream.ready;
                out_data = last_data_reg;
                out_keep = last_keep_reg;
                if (word_in && s_payload_last) begin
                    out_valid = 1'b1;
                    payload_ready_next = 1'b0;
                    hdr_ready_next = !hdr_valid_next;
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            hdr_ready_reg <= 1'b0;
            payload_ready_reg <= 1'b0;
            hdr_valid_reg <= 1'b0;
            hdr_err_reg <= 1'b0;
            pay_err_reg <= 1'b0;
            remain_reg <= '0;
        end else begin
            state <= state_next;
            hdr_ready_reg <= hdr_ready_next;
            payload_ready_reg <= payload_ready_next;
            hdr_valid_reg <= hdr_valid_next;
            hdr_err_reg <= hdr_err_next;
            pay_err_reg <= pay_err_next;
            remain_reg <= remain_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_ip) begin
            m_ip_source_ip <= s_ip_source_ip;
            m_ip_dest_ip <= s_ip_dest_ip;
        end
        if (store_udp) begin
            udp_hdr_reg.hdr <= in_word.hdr;
        end
        if (store_last) begin
            last_data_reg <= s_payload_data;
            last_keep_reg <= out_keep;
        end
    end

    assign s_hdr_ready = hdr_ready_reg;
    assign s_payload_ready = payload_ready_reg;
    assign m_hdr_valid = hdr_valid_reg;
    assign error_header_early_termination = hdr_err_reg;
    assign error_payload_early_termination = pay_err_reg;

    // swap to host order
    assign m_udp_source_port = {udp_hdr_reg.lanes[0], udp_hdr_reg.lanes[1]};
    assign m_udp_dest_port = {udp_hdr_reg.lanes[2], udp_hdr_reg.lanes[3]};
    assign m_udp_length = {udp_hdr_reg.lanes[4], udp_hdr_reg.lanes[5]};
    assign m_udp_checksum = {udp_hdr_reg.lanes[6], udp_hdr_reg.lanes[7]};

    assign out_stream.data = out_data;
    assign out_stream.keep = out_keep;
    assign out_stream.valid = out_valid;
    assign out_stream.last = out_last;
    assign out_stream.user = out_user;

    // a pending header keeps its fields until taken
    a_hdr_valid_held: assert property (
        @(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=>
            m_hdr_valid && $stable(m_ip_source_ip) && $stable(m_udp_length)
    );

    // no payload word is taken between frames
    a_idle_no_payload: assert property (
        @(posedge clk) disable iff (rst)
        state == ST_IDLE |-> !s_payload_ready
    );

endmodule

// File: src/udp_rx_top.sv
//////////////////////////////
// UDP receive stage, 64-bit payload lanes
// frames with UDP length below 9 are not supported
//////////////////////////////
`timescale 1ns/1ps

module udp_rx_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               s_hdr_valid,
    output logic               s_hdr_ready,
    input  udp_pkg::ip_addr_t  s_ip_source_ip,
    input  udp_pkg::ip_addr_t  s_ip_dest_ip,
    input  stream_pkg::data_t  s_payload_data,
    input  stream_pkg::keep_t  s_payload_keep,
    input  logic               s_payload_valid,
    output logic               s_payload_ready,
    input  logic               s_payload_last,
    input  logic               s_payload_user,
    output logic               m_hdr_valid,
    input  logic               m_hdr_ready,
    output udp_pkg::ip_addr_t  m_ip_source_ip,
    output udp_pkg::ip_addr_t  m_ip_dest_ip,
    output udp_pkg::port_t     m_udp_source_port,
    output udp_pkg::port_t     m_udp_dest_port,
    output udp_pkg::port_t     m_udp_length,
    output udp_pkg::port_t     m_udp_checksum,
    output stream_pkg::data_t  m_payload_data,
    output stream_pkg::keep_t  m_payload_keep,
    output logic               m_payload_valid,
    input  logic               m_payload_ready,
    output logic               m_payload_last,
    output logic               m_payload_user,
    output logic               error_header_early_termination,
    output logic               error_payload_early_termination
);
    import stream_pkg::*;

    stream_if #(.DATA_BYTES(DATA_BYTES)) out_stream ();

    // port names match the controller one to one
    udp_rx_ctrl ctrl (
        .out_stream (out_stream.src),
        .*
    );

    stream_out_buf #(.DATA_BYTES(DATA_BYTES)) out_buf (
        .clk       (clk),
        .rst       (rst),
        .in_stream (out_stream.snk),
        .m_data    (m_payload_data),
        .m_keep    (m_payload_keep),
        .m_valid   (m_payload_valid),
        .m_last    (m_payload_last),
        .m_user    (m_payload_user),
        .m_ready   (m_payload_ready)
    );

endmodule

// File: test/tb_clock.sv
//////////////////////////////
// free-running testbench clock
//////////////////////////////
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

// File: test/tb_udp_rx.sv
//////////////////////////////
// frames start with a full 8-byte header word
// only the output side sees back-pressure
//////////////////////////////
`timescale 1ns/1ps

module tb_udp_rx;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] SEED = 32'd31878;

    logic clk;
    logic rst;
    logic s_hdr_valid, s_hdr_ready;
    logic [31:0] s_ip_source_ip, s_ip_dest_ip;
    logic [63:0] s_payload_data;
    logic [7:0] s_payload_keep;
    logic s_payload_valid, s_payload_ready, s_payload_last, s_payload_user;
    logic m_hdr_valid, m_hdr_ready;
    logic [31:0] m_ip_source_ip, m_ip_dest_ip;
    logic [15:0] m_udp_source_port, m_udp_dest_port, m_udp_length, m_udp_checksum;
    logic [63:0] m_payload_data;
    logic [7:0] m_payload_keep;
    logic m_payload_valid, m_payload_ready, m_payload_last, m_payload_user;
    logic error_header_early_termination, error_payload_early_termination;

    // expected outputs, filled when a frame is sent
    logic [127:0] exp_hdr[$];
    logic [63:0] exp_data[$];
    logic [7:0] exp_keep[$];
    logic exp_last[$];
    logic exp_user[$];
    int exp_hdr_err, exp_pay_err;
    int hdr_err_seen, pay_err_seen;

    logic [31:0] data_state;
    logic bp_on;

    tb_clock #(.PERIOD_NS(20.0)) clock_gen (.clk(clk));

    udp_rx_top UUT (
        .clk                             (clk),
        .rst                             (rst),
        .s_hdr_valid                     (s_hdr_valid),
        .s_hdr_ready                     (s_hdr_ready),
        .s_ip_source_ip                  (s_ip_source_ip),
        .s_ip_dest_ip                    (s_ip_dest_ip),
        .s_payload_data                  (s_payload_data),
        .s_payload_keep                  (s_payload_keep),
        .s_payload_valid                 (s_payload_valid),
        .s_payload_ready                 (s_payload_ready),
        .s_payload_last                  (s_payload_last),
        .s_payload_user                  (s_payload_user),
        .m_hdr_valid                     (m_hdr_valid),
        .m_hdr_ready                     (m_hdr_ready),
        .m_ip_source_ip                  (m_ip_source_ip),
        .m_ip_dest_ip                    (m_ip_dest_ip),
        .m_udp_source_port               (m_udp_source_port),
        .m_udp_dest_port                 (m_udp_dest_port),
        .m_udp_length                    (m_udp_length),
        .m_udp_checksum                  (m_udp_checksum),
        .m_payload_data                  (m_payload_data),
        .m_payload_keep                  (m_payload_keep),
        .m_payload_valid                 (m_payload_valid),
        .m_payload_ready                 (m_payload_ready),
        .m_payload_last                  (m_payload_last),
        .m_payload_user                  (m_payload_user),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [63:0] lane_mask(input logic [7:0] keep);
        logic [63:0] m;
        m = '0;
        for (int b = 0; b < 8; b++) begin
            m[b*8 +: 8] = {8{keep[b]}};
        end
        return m;
    endfunction

    // 0 clean, 1 header error, 2 payload error
    function automatic int expected_payload(input logic [7:0] frame[$], input int udp_len);
        int n_in, want, n_out, nw;
        logic [63:0] d;
        logic [7:0] k;
        n_in = frame.size() - 8;
        if (n_in <= 0) begin
            return 1;
        end
        want = udp_len - 8;
        n_out = (n_in < want) ? n_in : want;
        nw = (n_out + 7) / 8;
        for (int w = 0; w < nw; w++) begin
            d = '0;
            k = '0;
            for (int b = 0; b < 8; b++) begin
                if (w * 8 + b < n_out) begin
                    d[b*8 +: 8] = frame[8 + w * 8 + b];
                    k[b] = 1'b1;
                end
            end
            exp_data.push_back(d);
            exp_keep.push_back(k);
            exp_last.push_back(w == nw - 1);
            exp_user.push_back((w == nw - 1) && (n_in < want));
        end
        return (n_in < want) ? 2 : 0;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic rand_word(output logic [31:0] v);
        data_state = lcg_step(data_state);
        v = data_state;
    endtask

    task automatic send_header(input logic [31:0] sip, input logic [31:0] dip);
        int cycles;
        s_ip_source_ip = sip;
        s_ip_dest_ip = dip;
        s_hdr_valid = 1'b1;
        cycles = 0;
        while (!s_hdr_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_failure("timeout waiting for s_hdr_ready");
        end
        @(negedge clk);
        s_hdr_valid = 1'b0;
    endtask

    task automatic send_word(input logic [63:0] d, input logic [7:0] k, input logic l);
        int cycles;
        s_payload_data = d;
        s_payload_keep = k;
        s_payload_last = l;
        s_payload_valid = 1'b1;
        cycles = 0;
        while (!s_payload_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_failure("timeout waiting for s_payload_ready");
        end
        @(negedge clk);
        s_payload_valid = 1'b0;
    endtask

    // n_in counts the bytes after the header word
    task automatic run_frame(input int n_in, input int udp_len);
        logic [7:0] frame[$];
        logic [31:0] r, sip, dip;
        logic [15:0] sport, dport, csum, len16;
        logic [63:0] d;
        logic [7:0] k;
        int kind, nw, cycles;
        rand_word(sip);
        rand_word(dip);
        rand_word(r);
        sport = r[31:16];
        rand_word(r);
        dport = r[31:16];
        rand_word(r);
        csum = r[31:16];
        len16 = 16'(udp_len);
        // network byte order, high byte first
        frame = '{sport[15:8], sport[7:0], dport[15:8], dport[7:0],
                  len16[15:8], len16[7:0], csum[15:8], csum[7:0]};
        for (int i = 0; i < n_in; i++) begin
            rand_word(r);
            frame.push_back(r[23:16]);
        end
        kind = expected_payload(frame, udp_len);
        if (kind == 1) begin
            exp_hdr_err++;
        end else begin
            exp_hdr.push_back({sip, dip, sport, dport, len16, csum});
        end
        if (kind == 2) begin
            exp_pay_err++;
        end
        send_header(sip, dip);
        nw = (frame.size() + 7) / 8;
        for (int w = 0; w < nw; w++) begin
            d = '0;
            k = '0;
            for (int b = 0; b < 8; b++) begin
                if (w * 8 + b < frame.size()) begin
                    d[b*8 +: 8] = frame[w * 8 + b];
                    k[b] = 1'b1;
                end
            end
            send_word(d, k, w == nw - 1);
        end
        cycles = 0;
        while (!s_hdr_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_failure("timeout waiting for end of frame");
        end
        // error pulses land one cycle after the last word
        @(negedge clk);
        check_value("error_header_early_termination pulses", 64'(hdr_err_seen),
                    64'(exp_hdr_err));
        check_value("error_payload_early_termination pulses", 64'(pay_err_seen),
                    64'(exp_pay_err));
    endtask

    always @(posedge clk) begin : compare_outputs
        logic [127:0] h;
        if (!rst) begin
            if (error_header_early_termination) hdr_err_seen++;
            if (error_payload_early_termination) pay_err_seen++;
            if (m_hdr_valid && m_hdr_ready) begin
                if (exp_hdr.size() == 0) report_failure("header output with no frame expected");
                h = exp_hdr.pop_front();
                check_value("m_ip_source_ip", 64'(m_ip_source_ip), 64'(h[127:96]));
                check_value("m_ip_dest_ip", 64'(m_ip_dest_ip), 64'(h[95:64]));
                check_value("m_udp_source_port", 64'(m_udp_source_port), 64'(h[63:48]));
                check_value("m_udp_dest_port", 64'(m_udp_dest_port), 64'(h[47:32]));
                check_value("m_udp_length", 64'(m_udp_length), 64'(h[31:16]));
                check_value("m_udp_checksum", 64'(m_udp_checksum), 64'(h[15:0]));
            end
            if (m_payload_valid && m_payload_ready) begin
                if (exp_data.size() == 0) report_failure("payload word with none expected");
                check_value("m_payload_keep", 64'(m_payload_keep), 64'(exp_keep[0]));
                check_value("m_payload_data", m_payload_data & lane_mask(m_payload_keep),
                            exp_data[0] & lane_mask(exp_keep[0]));
                check_value("m_payload_last", 64'(m_payload_last), 64'(exp_last[0]));
                check_value("m_payload_user", 64'(m_payload_user), 64'(exp_user[0]));
                void'(exp_data.pop_front());
                void'(exp_keep.pop_front());
                void'(exp_last.pop_front());
                void'(exp_user.pop_front());
            end
        end
    end

    // output back-pressure, always ready unless enabled
    initial begin : drive_output_ready
        logic [31:0] bp_state;
        bp_state = lcg_step(SEED);
        m_payload_ready = 1'b1;
        m_hdr_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (bp_on) begin
                bp_state = lcg_step(bp_state);
                m_payload_ready = (bp_state[30:29] != 2'b00);
                m_hdr_ready = (bp_state[27:26] != 2'b00);
            end else begin
                m_payload_ready = 1'b1;
                m_hdr_ready = 1'b1;
            end
        end
    end

    initial begin
        logic [31:0] r;
        int want, n_in, cycles;
        rst = 1'b1;
        bp_on = 1'b0;
        data_state = SEED;
        s_hdr_valid = 1'b0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_payload_data = '0;
        s_payload_keep = '0;
        s_payload_valid = 1'b0;
        s_payload_last = 1'b0;
        s_payload_user = 1'b0;
        exp_hdr_err = 0;
        exp_pay_err = 0;
        hdr_err_seen = 0;
        pay_err_seen = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // exact frames of 8, 13 and 24 payload bytes
        run_frame(8, 16);
        run_frame(13, 21);
        run_frame(24, 32);
        // 16 bytes of padding past the UDP length
        run_frame(29, 21);
        // truncated payload
        run_frame(10, 32);
        // header word only, then a normal frame
        run_frame(0, 16);
        run_frame(13, 21);

        bp_on = 1'b1;
        for (int i = 0; i < 10; i++) begin
            rand_word(r);
            want = 1 + int'(r[21:16]);
            rand_word(r);
            n_in = want - 6 + int'(r[19:16]);
            if (n_in < 1) n_in = 1;
            run_frame(n_in, want + 8);
        end

        cycles = 0;
        while (exp_data.size() != 0 || exp_hdr.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_failure("timeout waiting for outputs to drain");
        end
        bp_on = 1'b0;
        $display("All tests passed!");
        $finish;
    end

endmodule
